//--- files.f
+incdir+hdl
hdl/jesd_tpl_pkg.sv
hdl/jesd_tpl_deframer.sv
hdl/jesd_tpl_data_format.sv
hdl/jesd_tpl_pn_monitor.sv
hdl/jesd_tpl_adc_channel.sv
hdl/jesd_tpl_adc_core.sv
sim/tb_jesd_tpl_adc.sv

//--- sim/tb_jesd_tpl_adc.sv
`timescale 1ns/1ns
`include "jesd_tpl_settings.svh"

module tb_jesd_tpl_adc;

  import jesd_tpl_pkg::*;

  localparam int NCH = `JESD_TPL_NUM_CHANNELS;
  localparam int CW = `JESD_TPL_CHANNEL_WIDTH;
  localparam int LW = `JESD_TPL_LANE_WIDTH;
  localparam int SYNC = `JESD_TPL_PN_SYNC_COUNT;

  logic clk;
  logic rst_n;
  logic link_valid;
  logic [`JESD_TPL_NUM_LANES*LW-1:0] link_data;
  logic [NCH-1:0] dfmt_enable;
  logic [NCH-1:0] dfmt_type;
  logic [NCH-1:0] dfmt_sign_extend;
  pn_sel_e [NCH-1:0] pn_seq_sel;
  logic [NCH-1:0] adc_valid;
  logic [NCH*32-1:0] adc_data;
  logic [NCH-1:0] pn_err;
  logic [NCH-1:0] pn_oos;

  // Expected response of the beat currently on the link inputs
  logic [NCH*32-1:0] exp_data;
  logic [NCH-1:0] pn_check;
  logic [NCH-1:0] exp_err;
  logic [NCH-1:0] exp_oos;
  // Two-stage copies so that stage 1 lines up with the DUT outputs
  logic [1:0] valid_pipe;
  logic [NCH*32-1:0] data_pipe [2];
  logic [NCH-1:0] chk_pipe [2];
  logic [NCH-1:0] err_pipe [2];
  logic [NCH-1:0] oos_pipe [2];
  logic [NCH-1:0] sel_res_q;
  logic rst_q = 1'b1;

  // Software PN generators with bit 0 as the newest stream bit
  logic [14:0] pn_reg [NCH];
  int good_run [NCH];
  int bad_run [NCH];
  logic [31:0] rand_state;
  int value_errors;
  int timeout_errors;

  jesd_tpl_adc_core i_jesd_tpl_adc_core (
    .clk (clk),
    .rst_n (rst_n),
    .link_valid (link_valid),
    .link_data (link_data),
    .dfmt_enable (dfmt_enable),
    .dfmt_type (dfmt_type),
    .dfmt_sign_extend (dfmt_sign_extend),
    .pn_seq_sel (pn_seq_sel),
    .pn_err (pn_err),
    .pn_oos (pn_oos),
    .adc_valid (adc_valid),
    .adc_data (adc_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ************************************************************
  // Reference model helpers
  // ************************************************************

  function automatic logic [31:0] next_rand();
    rand_state = rand_state ^ (rand_state << 13);
    rand_state = rand_state ^ (rand_state >> 17);
    rand_state = rand_state ^ (rand_state << 5);
    return rand_state;
  endfunction

  // Offset binary flips the MSB, then the top two bits are filled
  function automatic logic [15:0] format_ref(input logic [CW-1:0] s, input logic en,
                                             input logic offs, input logic sx);
    logic [CW-1:0] t;
    t = s;
    if (!en) begin
      return {2'b00, s};
    end
    if (offs) begin
      t[CW-1] = ~t[CW-1];
    end
    return sx ? {{2{t[CW-1]}}, t} : {2'b00, t};
  endfunction

  // Each slot is a sample plus random tail bits and goes out MSB octet first
  // Octet 0 of the lane word is the first octet on the wire
  function automatic logic [31:0] lane_word(input logic [CW-1:0] s0, input logic [CW-1:0] s1);
    logic [15:0] slot0;
    logic [15:0] slot1;
    logic [31:0] r;
    r = next_rand();
    slot0 = {s0, r[1:0]};
    slot1 = {s1, r[3:2]};
    return {slot1[7:0], slot1[15:8], slot0[7:0], slot0[15:8]};
  endfunction

  // Channel 0 carries PN7 (taps 7 and 6) and channel 1 carries PN15 (taps 15 and 14)
  // Stream bits fill the sample from its MSB down
  function automatic logic [CW-1:0] pn_sample(input int ch);
    logic [CW-1:0] s;
    logic nb;
    for (int b = CW - 1; b >= 0; b--) begin
      nb = (ch == 0) ? (pn_reg[ch][6] ^ pn_reg[ch][5]) : (pn_reg[ch][14] ^ pn_reg[ch][13]);
      s[b] = nb;
      pn_reg[ch] = {pn_reg[ch][13:0], nb};
    end
    return s;
  endfunction

  function automatic logic is_reserved(input pn_sel_e sel);
    return !(sel == PN_SEL_PN7 || sel == PN_SEL_PN15);
  endfunction

  // ************************************************************
  // Stimulus tasks
  // ************************************************************

  // Inputs change 2 ns after the rising edge
  // Between beats the link is idle and carries random words that must be ignored
  task automatic next_cycle();
    @(posedge clk);
    #2;
    link_valid = 1'b0;
    for (int k = 0; k < `JESD_TPL_NUM_LANES; k++) begin
      link_data[k*LW +: LW] = next_rand();
    end
  endtask

  task automatic idle(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic put_beat(input logic [NCH-1:0][1:0][CW-1:0] smp);
    for (int c = 0; c < NCH; c++) begin
      link_data[c*LW +: LW] = lane_word(smp[c][0], smp[c][1]);
      exp_data[c*32 +: 32] = {
        format_ref(smp[c][1], dfmt_enable[c], dfmt_type[c], dfmt_sign_extend[c]),
        format_ref(smp[c][0], dfmt_enable[c], dfmt_type[c], dfmt_sign_extend[c])};
    end
    link_valid = 1'b1;
  endtask

  task automatic random_beat();
    logic [NCH-1:0][1:0][CW-1:0] smp;
    logic [31:0] r;
    for (int c = 0; c < NCH; c++) begin
      r = next_rand();
      smp[c][0] = r[CW-1:0];
      smp[c][1] = r[CW+15:16];
    end
    next_cycle();
    put_beat(smp);
  endtask

  task automatic random_gap(input int max_len);
    logic [31:0] r;
    r = next_rand();
    idle(r % (max_len + 1));
  endtask

  // A corrupted beat has the first stream bit flipped, outside the history
  // that seeds the next prediction, so only this beat is bad
  task automatic pn_beat(input logic [NCH-1:0] corrupt);
    logic [NCH-1:0][1:0][CW-1:0] smp;
    for (int c = 0; c < NCH; c++) begin
      smp[c][0] = pn_sample(c);
      smp[c][1] = pn_sample(c);
      if (corrupt[c]) begin
        smp[c][0][CW-1] = ~smp[c][0][CW-1];
      end
    end
    next_cycle();
    for (int c = 0; c < NCH; c++) begin
      if (pn_check[c]) begin
        exp_err[c] = corrupt[c];
        good_run[c] = corrupt[c] ? 0 : good_run[c] + 1;
        bad_run[c] = corrupt[c] ? bad_run[c] + 1 : 0;
        if (bad_run[c] >= SYNC) begin
          exp_oos[c] = 1'b1;
        end else if (good_run[c] >= SYNC) begin
          exp_oos[c] = 1'b0;
        end
      end
    end
    put_beat(smp);
  endtask

  // Checking pauses while the select changes so the flush stays clean
  task automatic set_sel(input pn_sel_e sel0, input pn_sel_e sel1);
    pn_check = '0;
    idle(3);
    pn_seq_sel[0] = sel0;
    pn_seq_sel[1] = sel1;
    idle(3);
  endtask

  task automatic wait_oos(input int ch, input logic value, input int limit);
    int n;
    n = 0;
    while (pn_oos[ch] !== value && n < limit) begin
      next_cycle();
      n++;
    end
    if (pn_oos[ch] !== value) begin
      timeout_errors++;
      $display("Timeout: pn_oos of channel %0d never reached %0d", ch, value);
    end
  endtask

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while (adc_valid !== '0 && n < limit) begin
      next_cycle();
      n++;
    end
    if (adc_valid !== '0) begin
      timeout_errors++;
      $display("Timeout: adc_valid still high after the link went idle");
    end
  endtask

  // ************************************************************
  // Checking
  // ************************************************************

  always @(posedge clk) begin
    rst_q <= rst_n;
    valid_pipe <= {valid_pipe[0], link_valid};
    data_pipe[0] <= exp_data;
    data_pipe[1] <= data_pipe[0];
    chk_pipe[0] <= pn_check;
    chk_pipe[1] <= chk_pipe[0];
    err_pipe[0] <= exp_err;
    err_pipe[1] <= err_pipe[0];
    oos_pipe[0] <= exp_oos;
    oos_pipe[1] <= oos_pipe[0];
    for (int c = 0; c < NCH; c++) begin
      sel_res_q[c] <= is_reserved(pn_seq_sel[c]);
    end
  end

  reset_state: assert property (@(posedge clk)
    !rst_q |-> (adc_valid == '0 && pn_err == '0 && pn_oos == '1))
  else begin
    value_errors++;
    $display("Error: reset state adc_valid %h pn_err %h pn_oos %h",
             $sampled(adc_valid), $sampled(pn_err), $sampled(pn_oos));
  end

  valid_delay: assert property (@(posedge clk) disable iff (!rst_n)
    adc_valid == {NCH{valid_pipe[1]}})
  else begin
    value_errors++;
    $display("Error: adc_valid expected %h, got %h",
             {NCH{$sampled(valid_pipe[1])}}, $sampled(adc_valid));
  end

  data_match: assert property (@(posedge clk) disable iff (!rst_n)
    valid_pipe[1] |-> adc_data == data_pipe[1])
  else begin
    value_errors++;
    $display("Error: adc_data expected %h, got %h", $sampled(data_pipe[1]), $sampled(adc_data));
  end

  for (genvar i = 0; i < NCH; i++) begin : g_pn_checks
    err_match: assert property (@(posedge clk) disable iff (!rst_n)
      valid_pipe[1] && chk_pipe[1][i] |-> pn_err[i] == err_pipe[1][i])
    else begin
      value_errors++;
      $display("Error: pn_err[%0d] expected %h, got %h", i,
               $sampled(err_pipe[1][i]), $sampled(pn_err[i]));
    end

    // Holds across gaps as well, since the model only moves on beats
    oos_match: assert property (@(posedge clk) disable iff (!rst_n)
      chk_pipe[1][i] |-> pn_oos[i] == oos_pipe[1][i])
    else begin
      value_errors++;
      $display("Error: pn_oos[%0d] expected %h, got %h", i,
               $sampled(oos_pipe[1][i]), $sampled(pn_oos[i]));
    end

    reserved_hold: assert property (@(posedge clk) disable iff (!rst_n)
      sel_res_q[i] |-> pn_oos[i] && !pn_err[i])
    else begin
      value_errors++;
      $display("Error: pn_oos/pn_err[%0d] expected 1/0, got %h/%h", i,
               $sampled(pn_oos[i]), $sampled(pn_err[i]));
    end
  end

  // ************************************************************
  // Test sequence
  // ************************************************************

  initial begin
    rand_state = 32'h1883_71b4;
    value_errors = 0;
    timeout_errors = 0;
    rst_n = 1'b0;
    link_valid = 1'b0;
    link_data = '0;
    dfmt_enable = '0;
    dfmt_type = '0;
    dfmt_sign_extend = '0;
    pn_seq_sel[0] = PN_SEL_PN7;
    pn_seq_sel[1] = PN_SEL_PN15;
    exp_data = '0;
    pn_check = '0;
    exp_err = '0;
    exp_oos = '1;
    for (int c = 0; c < NCH; c++) begin
      pn_reg[c] = 15'h7fff;
      good_run[c] = 0;
      bad_run[c] = 0;
    end
    idle(10);
    rst_n = 1'b1;

    // Plain zero-extended samples
    repeat (40) random_beat();

    // Every format setting with the two channels set differently
    for (int m = 0; m < 8; m++) begin
      idle(2);
      {dfmt_enable[0], dfmt_type[0], dfmt_sign_extend[0]} = 3'(m);
      {dfmt_enable[1], dfmt_type[1], dfmt_sign_extend[1]} = 3'(m) ^ 3'b011;
      repeat (12) random_beat();
    end

    // Beats with gaps
    repeat (40) begin
      random_beat();
      random_gap(3);
    end

    // Prime the history, then run the reserved code on a live stream
    pn_beat('0);
    set_sel(pn_sel_e'(4'd9), pn_sel_e'(4'd15));
    repeat (20) pn_beat('0);
    set_sel(PN_SEL_PN7, PN_SEL_PN15);
    pn_check = '1;

    // Sync in with gaps between the beats
    repeat (24) begin
      pn_beat('0);
      random_gap(2);
    end
    wait_oos(0, 1'b0, 8);
    wait_oos(1, 1'b0, 8);

    // One bad beat, then a bad run on channel 0, then recovery
    repeat (4) pn_beat('0);
    pn_beat(2'b01);
    repeat (6) pn_beat('0);
    repeat (SYNC) pn_beat(2'b01);
    wait_oos(0, 1'b1, 8);
    repeat (SYNC + 4) pn_beat('0);
    wait_oos(0, 1'b0, 8);
    wait_drain(8);
    idle(4);

    $display("Checks done with %0d value errors and %0d timeouts",
             value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- hdl/jesd_tpl_adc_core.sv
`timescale 1ns/1ns
`include "jesd_tpl_settings.svh"

module jesd_tpl_adc_core (
  input  logic clk,
  input  logic rst_n,

  // Link layer side, one word per lane per clock
  input  logic link_valid,
  input  logic [`JESD_TPL_NUM_LANES*`JESD_TPL_LANE_WIDTH-1:0] link_data,

  // Per-channel formatting controls
  input  logic [`JESD_TPL_NUM_CHANNELS-1:0] dfmt_enable,
  input  logic [`JESD_TPL_NUM_CHANNELS-1:0] dfmt_type,
  input  logic [`JESD_TPL_NUM_CHANNELS-1:0] dfmt_sign_extend,

  // Per-channel PN monitor
  input  jesd_tpl_pkg::pn_sel_e [`JESD_TPL_NUM_CHANNELS-1:0] pn_seq_sel,
  output logic [`JESD_TPL_NUM_CHANNELS-1:0] pn_err,
  output logic [`JESD_TPL_NUM_CHANNELS-1:0] pn_oos,

  // Formatted samples, channel i in field i with sample 0 in the low half
  output logic [`JESD_TPL_NUM_CHANNELS-1:0] adc_valid,
  output logic [`JESD_TPL_NUM_CHANNELS*`JESD_TPL_FMT_WIDTH-1:0] adc_data
);

  localparam int NUM_CHANNELS = `JESD_TPL_NUM_CHANNELS;
  localparam int RAW_WIDTH = `JESD_TPL_RAW_WIDTH;
  localparam int FMT_WIDTH = `JESD_TPL_FMT_WIDTH;

  // Deframed samples, one cycle behind the link
  logic raw_valid;
  logic [NUM_CHANNELS*RAW_WIDTH-1:0] raw_data;

  // ************************************************************
  // Deframer
  // ************************************************************

  jesd_tpl_deframer i_deframer (
    .clk (clk),
    .rst_n (rst_n),
    .link_valid (link_valid),
    .link_data (link_data),
    .raw_valid (raw_valid),
    .raw_data (raw_data)
  );

  // ************************************************************
  // Channels
  // ************************************************************

  // Every channel shares the beat marker from the deframer
  for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_channel
    jesd_tpl_adc_channel i_channel (
      .clk (clk),
      .rst_n (rst_n),
      .raw_valid (raw_valid),
      .raw_data (raw_data[i*RAW_WIDTH +: RAW_WIDTH]),
      .dfmt_enable (dfmt_enable[i]),
      .dfmt_type (dfmt_type[i]),
      .dfmt_sign_extend (dfmt_sign_extend[i]),
      .pn_seq_sel (pn_seq_sel[i]),
      .adc_valid (adc_valid[i]),
      .fmt_data (adc_data[i*FMT_WIDTH +: FMT_WIDTH]),
      .pn_err (pn_err[i]),
      .pn_oos (pn_oos[i])
    );
  end

endmodule

//--- hdl/jesd_tpl_adc_channel.sv
`timescale 1ns/1ns
`include "jesd_tpl_settings.svh"

module jesd_tpl_adc_channel (
  input  logic clk,
  input  logic rst_n,
  input  logic raw_valid,
  input  logic [`JESD_TPL_RAW_WIDTH-1:0] raw_data,
  input  logic dfmt_enable,
  input  logic dfmt_type,
  input  logic dfmt_sign_extend,
  input  jesd_tpl_pkg::pn_sel_e pn_seq_sel,
  output logic adc_valid,
  output logic [`JESD_TPL_FMT_WIDTH-1:0] fmt_data,
  output logic pn_err,
  output logic pn_oos
);

  // ************************************************************
  // Data path
  // ************************************************************

  // Formatter adds one register stage to the raw samples
  jesd_tpl_data_format i_data_format (
    .clk (clk),
    .raw_data (raw_data),
    .dfmt_enable (dfmt_enable),
    .dfmt_type (dfmt_type),
    .dfmt_sign_extend (dfmt_sign_extend),
    .fmt_data (fmt_data)
  );

  // Valid is delayed by the same single stage as the formatter
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      adc_valid <= 1'b0;
    end else begin
      adc_valid <= raw_valid;
    end
  end

  // ************************************************************
  // Test pattern check
  // ************************************************************

  // The monitor looks at raw samples so formatting never hides a PN error
  jesd_tpl_pn_monitor i_pn_monitor (
    .clk (clk),
    .rst_n (rst_n),
    .raw_valid (raw_valid),
    .raw_data (raw_data),
    .pn_seq_sel (pn_seq_sel),
    .pn_err (pn_err),
    .pn_oos (pn_oos)
  );

endmodule

//--- hdl/jesd_tpl_pn_monitor.sv
`timescale 1ns/1ns
`include "jesd_tpl_settings.svh"

module jesd_tpl_pn_monitor (
  input  logic clk,
  input  logic rst_n,
  input  logic raw_valid,
  input  logic [`JESD_TPL_RAW_WIDTH-1:0] raw_data,
  input  jesd_tpl_pkg::pn_sel_e pn_seq_sel,
  output logic pn_err,
  output logic pn_oos
);

  import jesd_tpl_pkg::*;

  localparam int CHANNEL_WIDTH = `JESD_TPL_CHANNEL_WIDTH;
  localparam int DATA_PATH_WIDTH = `JESD_TPL_DATA_PATH_WIDTH;
  localparam int RAW_WIDTH = `JESD_TPL_RAW_WIDTH;
  // Longest generator is PN15, so 15 past bits seed any prediction
  localparam int HIST_WIDTH = 15;
  localparam int CNT_WIDTH = $clog2(`JESD_TPL_PN_SYNC_COUNT);
  localparam logic [CNT_WIDTH-1:0] CNT_LAST = CNT_WIDTH'(`JESD_TPL_PN_SYNC_COUNT - 1);

  // Beat bits in stream order, the oldest bit on top
  logic [RAW_WIDTH-1:0] rx_bits;
  logic [RAW_WIDTH-1:0] exp_bits;
  // Latest received bits, bit 0 being the most recent one
  logic [HIST_WIDTH-1:0] pn_hist;
  logic pn_seeded;
  pn_sel_e sel_q;
  logic [CNT_WIDTH-1:0] good_cnt;
  logic [CNT_WIDTH-1:0] bad_cnt;
  logic sel_reserved;
  logic sel_changed;
  logic beat_bad;

  // ************************************************************
  // Pattern prediction
  // ************************************************************

  // Runs the generator forward over one beat starting from past bits
  // state[j] holds the bit received j+1 steps ago
  // PN15 uses b[n] = b[n-14] ^ b[n-15] and PN7 uses b[n] = b[n-6] ^ b[n-7]
  function automatic logic [RAW_WIDTH-1:0] pn_predict(
    input logic [HIST_WIDTH-1:0] seed,
    input pn_sel_e sel
  );
    logic [HIST_WIDTH-1:0] state;
    logic [RAW_WIDTH-1:0] bits;
    logic next_bit;
    int n;
    state = seed;
    bits = '0;
    for (n = RAW_WIDTH - 1; n >= 0; n--) begin
      if (sel == PN_SEL_PN15) begin
        next_bit = state[13] ^ state[14];
      end else begin
        next_bit = state[5] ^ state[6];
      end
      bits[n] = next_bit;
      state = {state[HIST_WIDTH-2:0], next_bit};
    end
    return bits;
  endfunction

  // Samples are taken MSB first, sample 0 ahead of sample 1
  always_comb begin
    for (int s = 0; s < DATA_PATH_WIDTH; s++) begin
      rx_bits[RAW_WIDTH-1 - s*CHANNEL_WIDTH -: CHANNEL_WIDTH] =
        raw_data[s*CHANNEL_WIDTH +: CHANNEL_WIDTH];
    end
  end

  assign exp_bits = pn_predict(pn_hist, pn_seq_sel);
  assign beat_bad = (rx_bits != exp_bits);
  assign sel_reserved = (pn_seq_sel != PN_SEL_PN7) && (pn_seq_sel != PN_SEL_PN15);
  assign sel_changed = (pn_seq_sel != sel_q);

  // The next beat is always predicted from what was really received
  always_ff @(posedge clk) begin
    if (raw_valid) begin
      pn_hist <= rx_bits[HIST_WIDTH-1:0];
    end
  end

  // ************************************************************
  // Error flag and sync hysteresis
  // ************************************************************

  // The first valid beat after reset only seeds the history
  // Each counter saturates on its last step and then flips the sync state
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pn_seeded <= 1'b0;
      sel_q <= PN_SEL_PN7;
      good_cnt <= '0;
      bad_cnt <= '0;
      pn_err <= 1'b0;
      pn_oos <= 1'b1;
    end else begin
      sel_q <= pn_seq_sel;
      pn_err <= 1'b0;
      if (raw_valid) begin
        pn_seeded <= 1'b1;
      end
      if (sel_reserved) begin
        // No pattern to check against
        good_cnt <= '0;
        bad_cnt <= '0;
        pn_oos <= 1'b1;
      end else if (sel_changed) begin
        good_cnt <= '0;
        bad_cnt <= '0;
      end else if (raw_valid && pn_seeded) begin
        pn_err <= beat_bad;
        if (beat_bad) begin
          good_cnt <= '0;
          if (bad_cnt == CNT_LAST) begin
            pn_oos <= 1'b1;
          end else begin
            bad_cnt <= bad_cnt + 1'b1;
          end
        end else begin
          bad_cnt <= '0;
          if (good_cnt == CNT_LAST) begin
            pn_oos <= 1'b0;
          end else begin
            good_cnt <= good_cnt + 1'b1;
          end
        end
      end
    end
  end

endmodule

//--- hdl/jesd_tpl_data_format.sv
`timescale 1ns/1ns
`include "jesd_tpl_settings.svh"

module jesd_tpl_data_format (
  input  logic clk,
  input  logic [`JESD_TPL_RAW_WIDTH-1:0] raw_data,
  input  logic dfmt_enable,
  input  logic dfmt_type,
  input  logic dfmt_sign_extend,
  output logic [`JESD_TPL_FMT_WIDTH-1:0] fmt_data
);

  localparam int CHANNEL_WIDTH = `JESD_TPL_CHANNEL_WIDTH;
  localparam int SAMPLE_WIDTH = `JESD_TPL_SAMPLE_WIDTH;
  localparam int DATA_PATH_WIDTH = `JESD_TPL_DATA_PATH_WIDTH;
  // Bits added above the converter MSB
  localparam int EXT_BITS = SAMPLE_WIDTH - CHANNEL_WIDTH;

  // Formatted beat before the output register
  logic [`JESD_TPL_FMT_WIDTH-1:0] fmt_next;

  // Format a single converter sample
  // With formatting off the MSB is left alone and the upper bits are zero
  // Offset binary turns into two's complement by flipping the MSB
  // The resulting MSB then fills the upper bits when sign extension is on
  function automatic logic [SAMPLE_WIDTH-1:0] format_sample(
    input logic [CHANNEL_WIDTH-1:0] sample,
    input logic enable,
    input logic offset_binary,
    input logic sign_extend
  );
    logic msb;
    logic [EXT_BITS-1:0] ext;
    msb = sample[CHANNEL_WIDTH-1] ^ (enable & offset_binary);
    ext = (enable & sign_extend) ? {EXT_BITS{msb}} : '0;
    return {ext, msb, sample[CHANNEL_WIDTH-2:0]};
  endfunction

  // Both samples of the beat are handled side by side
  always_comb begin
    for (int s = 0; s < DATA_PATH_WIDTH; s++) begin
      fmt_next[s*SAMPLE_WIDTH +: SAMPLE_WIDTH] = format_sample(
        raw_data[s*CHANNEL_WIDTH +: CHANNEL_WIDTH],
        dfmt_enable,
        dfmt_type,
        dfmt_sign_extend
      );
    end
  end

  // One pipeline stage, matched by the valid delay in the channel
  always_ff @(posedge clk) begin
    fmt_data <= fmt_next;
  end

endmodule

//--- hdl/jesd_tpl_deframer.sv
`timescale 1ns/1ns
`include "jesd_tpl_settings.svh"

module jesd_tpl_deframer (
  input  logic clk,
  input  logic rst_n,
  input  logic link_valid,
  input  logic [`JESD_TPL_NUM_LANES*`JESD_TPL_LANE_WIDTH-1:0] link_data,
  output logic raw_valid,
  output logic [`JESD_TPL_NUM_CHANNELS*`JESD_TPL_RAW_WIDTH-1:0] raw_data
);

  import jesd_tpl_pkg::*;

  localparam int NUM_LANES = `JESD_TPL_NUM_LANES;
  localparam int NUM_CHANNELS = `JESD_TPL_NUM_CHANNELS;
  localparam int LANE_WIDTH = `JESD_TPL_LANE_WIDTH;
  localparam int OCTETS = LANE_WIDTH / 8;
  localparam int CHANNEL_WIDTH = `JESD_TPL_CHANNEL_WIDTH;
  localparam int SAMPLE_WIDTH = `JESD_TPL_SAMPLE_WIDTH;
  localparam int DATA_PATH_WIDTH = `JESD_TPL_DATA_PATH_WIDTH;
  localparam int RAW_WIDTH = `JESD_TPL_RAW_WIDTH;
  // Low bits of each slot that carry no converter data
  localparam int TAIL_BITS = SAMPLE_WIDTH - CHANNEL_WIDTH;

  // Lane words exactly as they arrive, octet 0 in the low byte
  lane_word_u wire_word [NUM_LANES];
  // Lane words with each slot turned MSB octet on top
  lane_word_u slot_word [NUM_LANES];
  // Samples of all channels before the output register
  logic [NUM_CHANNELS*RAW_WIDTH-1:0] raw_next;

  // ************************************************************
  // Octet reorder
  // ************************************************************

  // Each slot is sent MSB octet first, so the first octet of a slot
  // lands in the low byte of the link word and has to move up
  // Swapping the octets of every pair gives slot s the octets 2s and 2s+1
  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      wire_word[k] = link_data[k*LANE_WIDTH +: LANE_WIDTH];
      for (int o = 0; o < OCTETS; o++) begin
        slot_word[k].octets[o ^ 1] = wire_word[k].octets[o];
      end
    end
  end

  // ************************************************************
  // Sample mapping
  // ************************************************************

  // Converter i is carried alone on lane i
  // Sample 0 of each channel goes to the low end of its raw field
  // The tail bits under each sample are dropped here
  always_comb begin
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      for (int s = 0; s < DATA_PATH_WIDTH; s++) begin
        raw_next[c*RAW_WIDTH + s*CHANNEL_WIDTH +: CHANNEL_WIDTH] =
          slot_word[c].slots[s][SAMPLE_WIDTH-1:TAIL_BITS];
      end
    end
  end

  // Raw samples are plain payload and simply follow the link
  always_ff @(posedge clk) begin
    raw_data <= raw_next;
  end

  // Beat marker travels alongside the samples
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      raw_valid <= 1'b0;
    end else begin
      raw_valid <= link_valid;
    end
  end

endmodule

//--- hdl/jesd_tpl_pkg.sv
`include "jesd_tpl_settings.svh"

package jesd_tpl_pkg;

  // ************************************************************
  // Lane word views
  // ************************************************************

  // One octet as received on the serial lane
  typedef logic [7:0] octet_t;

  // One sample slot with the converter bits on top and tail bits below
  typedef logic [`JESD_TPL_SAMPLE_WIDTH-1:0] slot_t;

  // A lane word is decoded in two ways by the deframer
  // The octet view is used to undo the wire order of the octets
  // The slot view is then used to pull whole samples out of the
  // reordered word, slot 0 being the earlier frame of the beat
  typedef union packed {
    octet_t [`JESD_TPL_LANE_WIDTH/8-1:0] octets;
    slot_t [`JESD_TPL_DATA_PATH_WIDTH-1:0] slots;
  } lane_word_u;

  // ************************************************************
  // PN monitor control
  // ************************************************************

  // Test pattern select for the per-channel PN monitor
  // Codes not listed here are reserved and keep the monitor out of sync
  typedef enum logic [3:0] {
    // Pattern from x^7 + x^6 + 1
    PN_SEL_PN7 = 4'd0,
    // Pattern from x^15 + x^14 + 1
    PN_SEL_PN15 = 4'd1
  } pn_sel_e;

endpackage

//--- hdl/jesd_tpl_settings.svh
`ifndef JESD_TPL_SETTINGS_SVH
`define JESD_TPL_SETTINGS_SVH

// ************************************************************
// Link geometry
// ************************************************************

// Number of 32-bit lanes delivered by the link layer
`define JESD_TPL_NUM_LANES 2
// Width of one lane word per clock
`define JESD_TPL_LANE_WIDTH 32
// Converters in the device, one per lane in this frame format
`define JESD_TPL_NUM_CHANNELS 2

// ************************************************************
// Sample geometry
// ************************************************************

// Converter resolution in bits
`define JESD_TPL_CHANNEL_WIDTH 14
// Slot width on the wire and width of each formatted output sample
`define JESD_TPL_SAMPLE_WIDTH 16
// Samples per channel carried in one beat
`define JESD_TPL_DATA_PATH_WIDTH 2
// Raw and formatted bits per channel per beat
`define JESD_TPL_RAW_WIDTH (`JESD_TPL_CHANNEL_WIDTH * `JESD_TPL_DATA_PATH_WIDTH)
`define JESD_TPL_FMT_WIDTH (`JESD_TPL_SAMPLE_WIDTH * `JESD_TPL_DATA_PATH_WIDTH)

// Consecutive good or bad valid beats before the PN sync state flips
`define JESD_TPL_PN_SYNC_COUNT 16

`endif
